//--- hw/vi_pkg.sv
// Widths, RV32 encodings and pipeline records shared by every vi_core block
package vi_pkg;

	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int MULT_STAGES = 5;
	localparam logic [XLEN-1:0] PC_STEP = 32'd4;

	// Major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_MUL     = 3'b000;

	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_SUB    = 7'b0100000;
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	typedef struct packed {
		logic [6:0]            funct7;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [REG_ADDR_W-1:0] rd;
		logic [6:0]            opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]           imm12;
		logic [REG_ADDR_W-1:0] rs1;
		logic [2:0]            funct3;
		logic [REG_ADDR_W-1:0] rd;
		logic [6:0]            opcode;
	} i_fmt_t;

	// Same word, two readings
	typedef union packed {
		r_fmt_t rtype;
		i_fmt_t itype;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MUL,
		ALU_NOP
	} alu_op_e;

	typedef struct packed {
		logic            valid;
		instr_u          instr;
		logic [XLEN-1:0] pc;
	} fetch_t;

	typedef struct packed {
		logic                  valid;
		logic [XLEN-1:0]       pc;
		alu_op_e               op;
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rd;
		logic                  use_imm;
		logic [XLEN-1:0]       imm;
		logic                  wr_en;
	} uop_t;

	typedef struct packed {
		uop_t            uop;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
	} exe_t;

	typedef struct packed {
		logic                  valid;
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  wr_en;
		logic [XLEN-1:0]       data;
	} wb_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  wr_en;
		logic [XLEN-1:0]       data;
	} retire_t;

endpackage

//--- hw/vi_fetch.sv
// Input side of vi_core: takes instruction words when not stalled, stamps the pc, feeds decode
module vi_fetch (
	input  logic           clk_i,
	input  logic           rst_i,
	input  logic           instr_valid_i,
	input  vi_pkg::instr_u instr_i,
	input  logic           stall_core_i,
	output vi_pkg::fetch_t fetch_o
);

	vi_pkg::fetch_t dec_q;
	logic [vi_pkg::XLEN-1:0] pc_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dec_q.valid <= 1'b0;
			pc_q <= '0;
		end else if (!stall_core_i) begin
			// Decode slot empties when nothing new arrives
			dec_q.valid <= instr_valid_i;
			if (instr_valid_i) begin
				dec_q.instr <= instr_i;
				dec_q.pc <= pc_q;
				pc_q <= pc_q + vi_pkg::PC_STEP;
			end
		end
	end

	assign fetch_o = dec_q;

endmodule

//--- hw/vi_decoder.sv
// Decode stage of vi_core: turns the fetched word into a micro-op for the bypass stage
module vi_decoder (
	input  vi_pkg::fetch_t fetch_i,
	output vi_pkg::uop_t   uop_o
);

	vi_pkg::r_fmt_t  r_view;
	vi_pkg::i_fmt_t  i_view;
	vi_pkg::alu_op_e op;
	logic            use_imm;

	assign r_view = fetch_i.instr.rtype;
	assign i_view = fetch_i.instr.itype;

	always_comb begin
		op = vi_pkg::ALU_NOP;
		use_imm = 1'b0;
		case (r_view.opcode)
			vi_pkg::OPC_OP: begin
				case ({r_view.funct7, r_view.funct3})
					{vi_pkg::F7_BASE, vi_pkg::F3_ADD_SUB}: op = vi_pkg::ALU_ADD;
					{vi_pkg::F7_SUB, vi_pkg::F3_ADD_SUB}:  op = vi_pkg::ALU_SUB;
					{vi_pkg::F7_BASE, vi_pkg::F3_AND}:     op = vi_pkg::ALU_AND;
					{vi_pkg::F7_BASE, vi_pkg::F3_OR}:      op = vi_pkg::ALU_OR;
					{vi_pkg::F7_BASE, vi_pkg::F3_XOR}:     op = vi_pkg::ALU_XOR;
					{vi_pkg::F7_MULDIV, vi_pkg::F3_MUL}:   op = vi_pkg::ALU_MUL;
					default:                               op = vi_pkg::ALU_NOP;
				endcase
			end
			vi_pkg::OPC_OP_IMM: begin
				// Only ADDI from the immediate group
				if (i_view.funct3 == vi_pkg::F3_ADD_SUB) begin
					op = vi_pkg::ALU_ADD;
					use_imm = 1'b1;
				end
			end
			default: op = vi_pkg::ALU_NOP;
		endcase
	end

	always_comb begin
		uop_o = '0;
		uop_o.valid = fetch_i.valid;
		uop_o.pc = fetch_i.pc;
		uop_o.op = op;
		uop_o.use_imm = use_imm;
		// A NOP keeps zero indices so it never waits on a hazard
		if (op != vi_pkg::ALU_NOP) begin
			uop_o.rs1 = r_view.rs1;
			uop_o.rs2 = use_imm ? '0 : r_view.rs2;
			uop_o.rd = r_view.rd;
			uop_o.wr_en = 1'b1;
			if (use_imm) begin
				uop_o.imm = {{(vi_pkg::XLEN-12){i_view.imm12[11]}}, i_view.imm12};
			end
		end
	end

endmodule

//--- hw/vi_int_registers.sv
// Integer register file of vi_core, two reads and one write per cycle, x0 hardwired to zero
module vi_int_registers (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic [vi_pkg::REG_ADDR_W-1:0] read_addr_a_i,
	input  logic [vi_pkg::REG_ADDR_W-1:0] read_addr_b_i,
	input  logic [vi_pkg::REG_ADDR_W-1:0] write_addr_i,
	input  logic                          write_enable_i,
	input  logic [vi_pkg::XLEN-1:0]       write_data_i,
	output logic [vi_pkg::XLEN-1:0]       read_data_a_o,
	output logic [vi_pkg::XLEN-1:0]       read_data_b_o
);

	// No storage behind index 0
	logic [vi_pkg::XLEN-1:0] regs [1:2**vi_pkg::REG_ADDR_W-1];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 1; i < 2**vi_pkg::REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable_i && write_addr_i != '0) begin
			regs[write_addr_i] <= write_data_i;
		end
	end

	// Same-cycle write is not visible here, writeback forwarding covers it
	assign read_data_a_o = (read_addr_a_i == '0) ? '0 : regs[read_addr_a_i];
	assign read_data_b_o = (read_addr_b_i == '0) ? '0 : regs[read_addr_b_i];

endmodule

//--- hw/vi_bypass_ctrl.sv
// Hazard unit of vi_core: picks forwarded operands, stalls decode and issues into execute
module vi_bypass_ctrl (
	input  vi_pkg::uop_t                          uop_i,
	input  logic [vi_pkg::XLEN-1:0]               reg_a_i,
	input  logic [vi_pkg::XLEN-1:0]               reg_b_i,
	input  vi_pkg::wb_t                           alu_res_i,
	input  vi_pkg::wb_t [vi_pkg::MULT_STAGES-1:0] mult_stage_i,
	input  vi_pkg::wb_t                           wb_res_i,
	output vi_pkg::exe_t                          exe_o,
	output logic                                  stall_core_o
);

	logic alu_mul;
	logic mul_in_flight;
	logic busy_a;
	logic busy_b;

	function automatic logic hit(input vi_pkg::wb_t res, input logic [vi_pkg::REG_ADDR_W-1:0] src);
		return res.wr_en && res.rd == src && src != '0;
	endfunction

	// Source still waits on a MUL result that is not computed yet
	function automatic logic src_busy(input logic [vi_pkg::REG_ADDR_W-1:0] src);
		logic busy;
		busy = 1'b0;
		if (!(alu_res_i.valid && hit(alu_res_i, src))) begin
			if (alu_mul && hit(alu_res_i, src)) begin
				busy = 1'b1;
			end
			for (int s = 0; s < vi_pkg::MULT_STAGES - 1; s++) begin
				if (mult_stage_i[s].valid && hit(mult_stage_i[s], src)) begin
					busy = 1'b1;
				end
			end
		end
		return busy;
	endfunction

	// Youngest producer wins
	function automatic logic [vi_pkg::XLEN-1:0] fwd(input logic [vi_pkg::REG_ADDR_W-1:0] src,
			input logic [vi_pkg::XLEN-1:0] reg_val);
		if (alu_res_i.valid && hit(alu_res_i, src)) begin
			return alu_res_i.data;
		end
		if (mult_stage_i[vi_pkg::MULT_STAGES-1].valid && hit(mult_stage_i[vi_pkg::MULT_STAGES-1], src)) begin
			return mult_stage_i[vi_pkg::MULT_STAGES-1].data;
		end
		if (wb_res_i.valid && hit(wb_res_i, src)) begin
			return wb_res_i.data;
		end
		return reg_val;
	endfunction

	always_comb begin
		// A MUL sitting in execute shows up as a non-valid record that still owns its rd
		alu_mul = !alu_res_i.valid && alu_res_i.wr_en;
		mul_in_flight = alu_mul;
		for (int s = 0; s < vi_pkg::MULT_STAGES - 1; s++) begin
			mul_in_flight = mul_in_flight | mult_stage_i[s].valid;
		end

		busy_a = src_busy(uop_i.rs1);
		busy_b = !uop_i.use_imm && src_busy(uop_i.rs2);

		// Non-MUL ops wait for older MULs so retire stays in order
		stall_core_o = uop_i.valid &&
			(busy_a || busy_b || (uop_i.op != vi_pkg::ALU_MUL && mul_in_flight));

		exe_o = '0;
		if (uop_i.valid && !stall_core_o) begin
			exe_o.uop = uop_i;
			exe_o.a = fwd(uop_i.rs1, reg_a_i);
			exe_o.b = uop_i.use_imm ? uop_i.imm : fwd(uop_i.rs2, reg_b_i);
		end
	end

endmodule

//--- hw/vi_int_alu.sv
// Execute stage of vi_core: single-cycle integer ops, hands MULs on to the multiplier
module vi_int_alu (
	input  logic         clk_i,
	input  logic         rst_i,
	input  vi_pkg::exe_t exe_i,
	output vi_pkg::wb_t  alu_res_o,
	output vi_pkg::exe_t mult_o
);

	vi_pkg::exe_t exe_q;
	logic is_mul;
	logic [vi_pkg::XLEN-1:0] result;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			exe_q <= '0;
		end else begin
			exe_q <= exe_i;
		end
	end

	assign is_mul = exe_q.uop.valid && exe_q.uop.op == vi_pkg::ALU_MUL;

	always_comb begin
		case (exe_q.uop.op)
			vi_pkg::ALU_ADD: result = exe_q.a + exe_q.b;
			vi_pkg::ALU_SUB: result = exe_q.a - exe_q.b;
			vi_pkg::ALU_AND: result = exe_q.a & exe_q.b;
			vi_pkg::ALU_OR:  result = exe_q.a | exe_q.b;
			vi_pkg::ALU_XOR: result = exe_q.a ^ exe_q.b;
			default:         result = '0;
		endcase
	end

	// For a MUL valid drops but rd and wr_en stay, so decode sees it in flight
	always_comb begin
		alu_res_o.valid = exe_q.uop.valid && !is_mul;
		alu_res_o.pc = exe_q.uop.pc;
		alu_res_o.rd = exe_q.uop.rd;
		alu_res_o.wr_en = exe_q.uop.wr_en;
		alu_res_o.data = result;
	end

	assign mult_o = is_mul ? exe_q : '0;

endmodule

//--- hw/vi_mult_pipe.sv
// Five-stage 32x32 multiplier of vi_core keeping the low word, micro-ops ride alongside
module vi_mult_pipe (
	input  logic                                  clk_i,
	input  logic                                  rst_i,
	input  vi_pkg::exe_t                          mult_i,
	output vi_pkg::wb_t [vi_pkg::MULT_STAGES-1:0] stage_o
);

	vi_pkg::uop_t [vi_pkg::MULT_STAGES-1:0] uop_q;

	logic [vi_pkg::XLEN-1:0]   s1_a;
	logic [vi_pkg::XLEN-1:0]   s1_b;
	logic [vi_pkg::XLEN-1:0]   s2_ll;
	logic [vi_pkg::XLEN/2-1:0] s2_lh;
	logic [vi_pkg::XLEN/2-1:0] s2_hl;
	logic [vi_pkg::XLEN-1:0]   s3_ll;
	logic [vi_pkg::XLEN/2-1:0] s3_cross;
	logic [vi_pkg::XLEN/2-1:0] s4_hi;
	logic [vi_pkg::XLEN/2-1:0] s4_lo;
	logic [vi_pkg::XLEN-1:0]   s5_prod;

	// Entry 0 is the youngest
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			uop_q <= '0;
		end else begin
			uop_q <= {uop_q[vi_pkg::MULT_STAGES-2:0], mult_i.uop};
		end
	end

	// Low word only needs ll plus the low halves of the cross terms
	always_ff @(posedge clk_i) begin
		s1_a <= mult_i.a;
		s1_b <= mult_i.b;

		s2_ll <= s1_a[vi_pkg::XLEN/2-1:0] * s1_b[vi_pkg::XLEN/2-1:0];
		s2_lh <= s1_a[vi_pkg::XLEN/2-1:0] * s1_b[vi_pkg::XLEN-1:vi_pkg::XLEN/2];
		s2_hl <= s1_a[vi_pkg::XLEN-1:vi_pkg::XLEN/2] * s1_b[vi_pkg::XLEN/2-1:0];

		s3_ll <= s2_ll;
		s3_cross <= s2_lh + s2_hl;

		s4_hi <= s3_ll[vi_pkg::XLEN-1:vi_pkg::XLEN/2] + s3_cross;
		s4_lo <= s3_ll[vi_pkg::XLEN/2-1:0];

		s5_prod <= {s4_hi, s4_lo};
	end

	always_comb begin
		for (int s = 0; s < vi_pkg::MULT_STAGES; s++) begin
			stage_o[s].valid = uop_q[s].valid;
			stage_o[s].pc = uop_q[s].pc;
			stage_o[s].rd = uop_q[s].rd;
			stage_o[s].wr_en = uop_q[s].wr_en;
			stage_o[s].data = '0;
		end
		stage_o[vi_pkg::MULT_STAGES-1].data = s5_prod;
	end

endmodule

//--- hw/vi_writeback.sv
// Output side of vi_core: one result per cycle into the register file and the retire port
module vi_writeback (
	input  logic            clk_i,
	input  logic            rst_i,
	input  vi_pkg::wb_t     alu_res_i,
	input  vi_pkg::wb_t     mult_res_i,
	output vi_pkg::wb_t     wb_o,
	output logic            retire_valid_o,
	output vi_pkg::retire_t retire_o
);

	vi_pkg::wb_t wb_q;

	// MUL and ALU results never arrive together, the hazard unit orders them
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wb_q <= '0;
		end else if (mult_res_i.valid) begin
			wb_q <= mult_res_i;
		end else if (alu_res_i.valid) begin
			wb_q <= alu_res_i;
		end else begin
			wb_q <= '0;
		end
	end

	assign wb_o = wb_q;
	assign retire_valid_o = wb_q.valid;

	always_comb begin
		retire_o.pc = wb_q.pc;
		retire_o.rd = wb_q.rd;
		retire_o.wr_en = wb_q.wr_en;
		retire_o.data = wb_q.data;
	end

endmodule

//--- hw/vi_core.sv
// Top of the vi_core integer pipeline, wires fetch through writeback
module vi_core (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic            instr_valid_i,
	input  vi_pkg::instr_u  instr_i,
	output logic            stall_o,
	output logic            retire_valid_o,
	output vi_pkg::retire_t retire_o
);

	// Fetch to decode
	vi_pkg::fetch_t fetch_dec;
	vi_pkg::uop_t   dec_uop;

	// Register file reads
	logic [vi_pkg::XLEN-1:0] reg_data_a;
	logic [vi_pkg::XLEN-1:0] reg_data_b;

	// Execute and multiplier
	vi_pkg::exe_t bypass_exe;
	vi_pkg::wb_t  alu_res;
	vi_pkg::exe_t mult_in;
	vi_pkg::wb_t [vi_pkg::MULT_STAGES-1:0] mult_stage;

	vi_pkg::wb_t wb_res;
	logic        stall_core;

	assign stall_o = stall_core;

	vi_fetch fetch (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.stall_core_i  (stall_core),
		.fetch_o       (fetch_dec)
	);

	vi_decoder decoder (
		.fetch_i (fetch_dec),
		.uop_o   (dec_uop)
	);

	vi_int_registers int_registers (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.read_addr_a_i  (dec_uop.rs1),
		.read_addr_b_i  (dec_uop.rs2),
		.write_addr_i   (wb_res.rd),
		.write_enable_i (wb_res.wr_en),
		.write_data_i   (wb_res.data),
		.read_data_a_o  (reg_data_a),
		.read_data_b_o  (reg_data_b)
	);

	vi_bypass_ctrl bypass_ctrl (
		.uop_i        (dec_uop),
		.reg_a_i      (reg_data_a),
		.reg_b_i      (reg_data_b),
		.alu_res_i    (alu_res),
		.mult_stage_i (mult_stage),
		.wb_res_i     (wb_res),
		.exe_o        (bypass_exe),
		.stall_core_o (stall_core)
	);

	vi_int_alu int_alu (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.exe_i     (bypass_exe),
		.alu_res_o (alu_res),
		.mult_o    (mult_in)
	);

	vi_mult_pipe mult_pipe (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.mult_i  (mult_in),
		.stage_o (mult_stage)
	);

	vi_writeback writeback (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.alu_res_i      (alu_res),
		.mult_res_i     (mult_stage[vi_pkg::MULT_STAGES-1]),
		.wb_o           (wb_res),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o)
	);

endmodule

//--- dv/vi_core_tb.sv
// Testbench for vi_core: LFSR instruction streams, each retire checked in order against an ISA model
module vi_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum int {MODE_ALU, MODE_CHAIN, MODE_MUL, MODE_X0, MODE_READ} mode_e;

	logic            clk;
	logic            rst;
	logic            instr_valid;
	vi_pkg::instr_u  instr;
	logic            stall;
	logic            retire_valid;
	vi_pkg::retire_t retire;

	logic [31:0]     lfsr_state = 32'hc601_1525;
	logic [31:0]     model_regs [32];
	logic [31:0]     model_pc;
	logic [4:0]      last_rd;
	vi_pkg::retire_t exp_q [$];
	logic            stall_seen;
	int              err_count;
	int              retire_count;
	int              test_count;
	int              cycle_count;
	int              cycle_limit;
	int              run_len = 60;

	vi_core UUT (
		.clk_i          (clk),
		.rst_i          (rst),
		.instr_valid_i  (instr_valid),
		.instr_i        (instr),
		.stall_o        (stall),
		.retire_valid_o (retire_valid),
		.retire_o       (retire)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit returned
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [31:0] alu_word(input logic [2:0] sel, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		case (sel)
			3'd0: return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
			3'd1: return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
			3'd2: return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
			3'd3: return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
			3'd4: return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
			3'd5: return {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011};
			default: return {lfsr_bits(12), rs1, 3'b000, rd, 7'b0010011};
		endcase
	endfunction

	function automatic logic [31:0] next_word(input mode_e mode, input int idx);
		logic [2:0] sel;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		sel = lfsr_bits(3);
		// Slot 5 is MUL, only the MUL mix may pick it
		if (sel == 3'd5) begin
			sel = 3'd6;
		end
		rd = lfsr_bits(5);
		rs1 = lfsr_bits(5);
		rs2 = lfsr_bits(5);
		case (mode)
			MODE_CHAIN: begin
				rs1 = last_rd;
				if (lfsr_bits(1)) begin
					rs2 = last_rd;
				end
			end
			MODE_MUL: begin
				if (lfsr_bits(1)) begin
					sel = 3'd5;
				end
				if (lfsr_bits(1)) begin
					rs1 = last_rd;
				end
			end
			MODE_X0: begin
				if (lfsr_bits(1)) begin
					rd = '0;
				end
				if (lfsr_bits(1)) begin
					rs1 = '0;
				end
				if (lfsr_bits(2) == 0) begin
					return lfsr_bits(32);
				end
			end
			MODE_READ: begin
				sel = 3'd0;
				rd = idx;
				rs1 = idx;
				rs2 = '0;
			end
			default: ;
		endcase
		last_rd = rd;
		return alu_word(sel, rd, rs1, rs2);
	endfunction

	// Sequential RV32 reference, one call per accepted word in program order
	function automatic void model_accept(input logic [31:0] w);
		vi_pkg::retire_t e;
		logic [31:0]     a;
		logic [31:0]     b;
		logic [31:0]     imm;
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		imm = {{20{w[31]}}, w[31:20]};
		e.pc = model_pc;
		e.rd = w[11:7];
		e.wr_en = 1'b1;
		e.data = '0;
		if (w[6:0] == 7'b0110011) begin
			case ({w[31:25], w[14:12]})
				10'b0000000_000: e.data = a + b;
				10'b0100000_000: e.data = a - b;
				10'b0000000_111: e.data = a & b;
				10'b0000000_110: e.data = a | b;
				10'b0000000_100: e.data = a ^ b;
				10'b0000001_000: e.data = a * b;
				default:         e.wr_en = 1'b0;
			endcase
		end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin
			e.data = a + imm;
		end else begin
			e.wr_en = 1'b0;
		end
		if (e.wr_en && e.rd != 5'd0) begin
			model_regs[e.rd] = e.data;
		end
		model_pc = model_pc + 32'd4;
		exp_q.push_back(e);
	endfunction

	always @(negedge clk) begin
		vi_pkg::retire_t exp;
		if (!rst && retire_valid) begin
			retire_count++;
			if (exp_q.size() == 0) begin
				$display("ERROR: retire at pc %h with no instruction outstanding", retire.pc);
				err_count++;
			end else begin
				exp = exp_q.pop_front();
				if (retire.pc !== exp.pc) begin
					$display("FAILED retire_o.pc: got %h, expected %h", retire.pc, exp.pc);
					err_count++;
				end
				if (retire.wr_en !== exp.wr_en) begin
					$display("FAILED retire_o.wr_en: got %h, expected %h at pc %h",
						retire.wr_en, exp.wr_en, exp.pc);
					err_count++;
				end
				// rd and data only matter for a real write
				if (exp.wr_en && retire.rd !== exp.rd) begin
					$display("FAILED retire_o.rd: got %h, expected %h at pc %h",
						retire.rd, exp.rd, exp.pc);
					err_count++;
				end
				if (exp.wr_en && retire.data !== exp.data) begin
					$display("FAILED retire_o.data: got %h, expected %h at pc %h",
						retire.data, exp.data, exp.pc);
					err_count++;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("ERROR: run stopped at cycle limit %0d with %0d instructions outstanding",
				cycle_limit, exp_q.size());
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic check_idle();
		int errs_before;
		errs_before = err_count;
		repeat (8) begin
			@(negedge clk);
			if (stall !== 1'b0) begin
				$display("FAILED stall_o: got %h, expected 0", stall);
				err_count++;
			end
			if (retire_valid !== 1'b0) begin
				$display("FAILED retire_valid_o: got %h, expected 0", retire_valid);
				err_count++;
			end
		end
		stall_seen = stall;
		test_count++;
		$display("test %0d idle after reset: %0d errors", test_count, err_count - errs_before);
	endtask

	task automatic run_test(input string name, input mode_e mode, input int count,
			input int gap_level);
		int errs_before;
		int generated;
		int accepted;
		int stalls;
		errs_before = err_count;
		generated = 0;
		accepted = 0;
		stalls = 0;
		while (accepted < count) begin
			@(posedge clk);
			if (instr_valid && !stall_seen) begin
				model_accept(instr);
				accepted++;
			end
			// A word offered under stall is held until it is taken
			if (!instr_valid || !stall_seen) begin
				if (generated < count && lfsr_bits(2) >= gap_level) begin
					instr <= next_word(mode, generated);
					instr_valid <= 1'b1;
					generated++;
				end else begin
					instr_valid <= 1'b0;
				end
			end
			@(negedge clk);
			stall_seen = stall;
			if (stall_seen) begin
				stalls++;
			end
		end
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		if (mode == MODE_MUL && stalls == 0) begin
			$display("ERROR: no stall seen while MULs and dependent ops were issued");
			err_count++;
		end
		test_count++;
		$display("test %0d %s: %0d accepted, %0d stall cycles, %0d errors",
			test_count, name, accepted, stalls, err_count - errs_before);
	endtask

	initial begin
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		stall_seen = 1'b0;
		err_count = 0;
		retire_count = 0;
		test_count = 0;
		cycle_count = 0;
		model_pc = '0;
		last_rd = '0;
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		cycle_limit = 8 * (5 * run_len + 32) + 200;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		check_idle();
		run_test("independent ALU ops", MODE_ALU, run_len, 0);
		run_test("dependent chains", MODE_CHAIN, run_len, 1);
		run_test("MUL and ALU mix", MODE_MUL, run_len, 0);
		run_test("valid gaps and held words", MODE_MUL, run_len, 2);
		run_test("x0 writes and unknown words", MODE_X0, run_len, 1);
		run_test("register readback", MODE_READ, 32, 0);
		repeat (10) @(posedge clk);
		$display("%0d tests, %0d instructions retired, %0d errors",
			test_count, retire_count, err_count);
		if (err_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- vi_core.f
hw/vi_pkg.sv
hw/vi_fetch.sv
hw/vi_decoder.sv
hw/vi_int_registers.sv
hw/vi_bypass_ctrl.sv
hw/vi_int_alu.sv
hw/vi_mult_pipe.sv
hw/vi_writeback.sv
hw/vi_core.sv
dv/vi_core_tb.sv

//--- Bender.yml
package:
  name: vi_core

sources:
  - hw/vi_pkg.sv
  - hw/vi_fetch.sv
  - hw/vi_decoder.sv
  - hw/vi_int_registers.sv
  - hw/vi_bypass_ctrl.sv
  - hw/vi_int_alu.sv
  - hw/vi_mult_pipe.sv
  - hw/vi_writeback.sv
  - hw/vi_core.sv
  - target: simulation
    files:
      - dv/vi_core_tb.sv
